/* Bender.yml */
package:
  name: nrdivider

sources:
  - files:
      - verilog/nrDivPkg.sv
      - verilog/radix16Mult.sv
      - verilog/fmad.sv
      - verilog/newtonRaphsonReciprocal.sv
      - verilog/divNormalize.sv
      - verilog/nrDivider.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/nrDividerTb.sv

/* nrDivider.f */
+incdir+include
verilog/nrDivPkg.sv
verilog/radix16Mult.sv
verilog/fmad.sv
verilog/newtonRaphsonReciprocal.sv
verilog/divNormalize.sv
verilog/nrDivider.sv
verif/nrDividerTb.sv

/* include/nrDivTbUtil.svh */
// testbench helpers for the divider: LCG, reference model and compare tasks, included in the tb
`ifndef NR_DIV_TB_UTIL_SVH
`define NR_DIV_TB_UTIL_SVH

logic [31:0] lcgState;

function automatic logic [31:0] nextRandom();
  lcgState = lcgState * 32'd1664525 + 32'd1013904223;
  return lcgState;
endfunction

// 1/(1.125 + 0.25k) scaled by 2^FRAC_W is 2^(FRAC_W+3)/(9 + 2k)
function automatic logic [WORD_W-1:0] modelGuess(input int k);
  return WORD_W'((1 << (FRAC_W + 3)) / (9 + 2 * k));
endfunction

function automatic divResp_t modelDivide(input divReq_t r);
  divResp_t result;
  int lead;
  logic [WORD_W-1:0] mant;
  logic [WORD_W-1:0] x;
  logic [WORD_W-1:0] t;
  logic [PROD_W-1:0] e;
  logic [PROD_W-1:0] p;
  if (r.divisor == '0) begin
    result.quotient = '1;
    result.divByZero = 1'b1;
    return result;
  end
  lead = 0;
  while ((r.divisor >> (lead + 1)) != 0) begin
    lead++;
  end
  mant = WORD_W'(r.divisor) << (FRAC_W - lead);
  x = modelGuess(int'(mant[FRAC_W-1 -: 2]));
  for (int n = 0; n < NR_ITERS; n++) begin
    e = (PROD_W'(2) << (2 * FRAC_W)) - PROD_W'(mant) * PROD_W'(x);
    t = WORD_W'(e >> FRAC_W);
    p = PROD_W'(x) * PROD_W'(t);
    x = WORD_W'(p >> FRAC_W);
  end
  p = PROD_W'(r.dividend) * PROD_W'(x);
  result.quotient = DATA_W'(p >> (FRAC_W + lead));
  result.divByZero = 1'b0;
  return result;
endfunction

task automatic checkQuotient(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] expected);
  if (got !== expected) begin
    $display("MISMATCH time %0t signal resp.quotient got %0d expected %0d",
             $time, got, expected);
    failRun();
  end
endtask

task automatic checkDivByZero(input logic got, input logic expected);
  if (got !== expected) begin
    $display("MISMATCH time %0t signal resp.divByZero got %b expected %b",
             $time, got, expected);
    failRun();
  end
endtask

task automatic checkFlag(input string name, input logic got, input logic expected);
  if (got !== expected) begin
    $display("MISMATCH time %0t signal %s got %b expected %b", $time, name, got, expected);
    failRun();
  end
endtask

// truncation may lose at most one against the true integer quotient
task automatic checkNearExact(input divReq_t r, input logic [DATA_W-1:0] got);
  int exact;
  int diff;
  exact = int'(r.dividend) / int'(r.divisor);
  diff = int'(got) - exact;
  if (diff > 1 || diff < -1) begin
    $display("quotient %0d for %0d / %0d is more than 1 away from %0d at time %0t",
             got, r.dividend, r.divisor, exact, $time);
    failRun();
  end
endtask

`endif

/* verif/nrDividerTb.sv */
// testbench for the Newton-Raphson divider, random and directed divisions checked against a model
`timescale 1ns/1ps
`default_nettype none

module nrDividerTb
  import nrDivPkg::*;
();

  localparam int PERIOD = 100;
  localparam int NUM_RANDOM = 500;
  localparam int NUM_DIVS = NUM_RANDOM + 3 + 10 + 1;
  localparam int CYCLES_PER_DIV = 100;
  localparam int DONE_LIMIT = 200;

  logic     clock;
  logic     reset;
  logic     start;
  divReq_t  req;
  divResp_t resp;
  logic     busy;
  logic     done;

  task automatic failRun();
    $display("test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  `include "nrDivTbUtil.svh"

  nrDivider DUT (
    .clock,
    .reset,
    .start,
    .req,
    .resp,
    .busy,
    .done
  );

  always #(PERIOD / 2) clock = ~clock;

  // one division takes about 63 cycles, so this leaves ample margin
  initial begin
    #(PERIOD * (CYCLES_PER_DIV * NUM_DIVS + 20));
    $display("timeout: the divisions did not complete in the allotted time");
    failRun();
  end

  task automatic issue(input divReq_t r);
    @(posedge clock);
    #1;
    start = 1'b1;
    req = r;
    @(posedge clock);
    #1;
    start = 1'b0;
    checkFlag("busy", busy, 1'b1);
  endtask

  task automatic waitDone();
    int cycles;
    cycles = 0;
    while (!done) begin
      @(posedge clock);
      #1;
      cycles++;
      if (cycles > DONE_LIMIT) begin
        $display("no done pulse within %0d cycles of an accepted start", DONE_LIMIT);
        failRun();
      end
    end
  endtask

  task automatic runAndCheck(input logic [DATA_W-1:0] dividend,
                             input logic [DATA_W-1:0] divisor);
    divReq_t  r;
    divResp_t expected;
    r.dividend = dividend;
    r.divisor = divisor;
    expected = modelDivide(r);
    issue(r);
    waitDone();
    checkQuotient(resp.quotient, expected.quotient);
    checkDivByZero(resp.divByZero, expected.divByZero);
    if (divisor != '0) begin
      checkNearExact(r, resp.quotient);
    end
  endtask

  // a second start mid-division must not disturb the first one
  task automatic startWhileBusy();
    divReq_t  first;
    divReq_t  second;
    divResp_t expected;
    divResp_t held;
    first.dividend = 8'd200;
    first.divisor = 8'd7;
    second.dividend = 8'd13;
    second.divisor = 8'd3;
    expected = modelDivide(first);
    issue(first);
    repeat (3) @(posedge clock);
    #1;
    checkFlag("busy", busy, 1'b1);
    start = 1'b1;
    req = second;
    @(posedge clock);
    #1;
    start = 1'b0;
    waitDone();
    checkQuotient(resp.quotient, expected.quotient);
    checkDivByZero(resp.divByZero, expected.divByZero);
    held = resp;
    repeat (8) begin
      @(posedge clock);
      #1;
      checkQuotient(resp.quotient, held.quotient);
      checkDivByZero(resp.divByZero, held.divByZero);
    end
    checkFlag("busy", busy, 1'b0);
  endtask

  initial begin
    logic [DATA_W-1:0] dividend;
    logic [DATA_W-1:0] divisor;
    clock = 1'b0;
    reset = 1'b1;
    start = 1'b0;
    req = '0;
    lcgState = 32'h5ea;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    repeat (6) begin
      checkFlag("busy", busy, 1'b0);
      checkFlag("done", done, 1'b0);
      @(posedge clock);
      #1;
    end
    for (int n = 0; n < NUM_RANDOM; n++) begin
      dividend = DATA_W'(nextRandom() >> 16);
      do begin
        divisor = DATA_W'(nextRandom() >> 16);
      end while (divisor == '0);
      runAndCheck(dividend, divisor);
    end
    runAndCheck(8'd0, 8'd0);
    runAndCheck(8'd255, 8'd0);
    runAndCheck(DATA_W'(nextRandom() >> 16), 8'd0);
    // 160 and 208 reach the middle guess entries
    for (int k = 0; k < 2; k++) begin
      dividend = (k == 0) ? 8'd0 : 8'd255;
      runAndCheck(dividend, 8'd1);
      runAndCheck(dividend, 8'd160);
      runAndCheck(dividend, 8'd208);
      runAndCheck(dividend, 8'd128);
      runAndCheck(dividend, 8'd255);
    end
    startWhileBusy();
    $display("test passed");
    $finish;
  end

endmodule : nrDividerTb

`default_nettype wire

/* verilog/divNormalize.sv */
// combinational leading-one normalizer mapping the divisor into [1, 2)
`timescale 1ns/1ps
`default_nettype none

module divNormalize
  import nrDivPkg::*;
(
  input  logic [DATA_W-1:0] divisor,
  output normDivisor_t      norm
);

  logic [SHIFT_W-1:0] lead;
  logic [WORD_W-1:0]  widened;

  // priority encoder, highest set bit wins
  always_comb begin
    lead = '0;
    for (int i = 0; i < DATA_W; i++) begin
      if (divisor[i]) begin
        lead = SHIFT_W'(i);
      end
    end
  end

  assign widened = WORD_W'(divisor);

  // leading one lands on bit FRAC_W, zeros shifted in below
  always_comb begin
    norm.isZero = (divisor == '0);
    norm.shift = lead;
    norm.mant = widened << (FRAC_W - lead);
  end

endmodule : divNormalize

`default_nettype wire

/* verilog/fmad.sv */
// fused multiply-add, addend plus or minus the product of two fixed-point words
`timescale 1ns/1ps
`default_nettype none

module fmad
  import nrDivPkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  logic              start,
  input  logic [WORD_W-1:0] fmadMulIn1,
  input  logic [WORD_W-1:0] fmadMulIn2,
  input  logic [PROD_W-1:0] fmadAddIn,
  input  logic              negate,
  output logic [PROD_W-1:0] fmadOut,
  output logic              fmadDone
);

  logic [PROD_W-1:0] product;
  logic              mulDone;
  logic [PROD_W-1:0] addend;
  logic              negLatch;

  radix16Mult fmadMult (
    .clock,
    .reset,
    .start,
    .mulIn1(fmadMulIn1),
    .mulIn2(fmadMulIn2),
    .mulOut(product),
    .done  (mulDone)
  );

  // addend and sign captured with the operands
  always_ff @(posedge clock) begin
    if (start) begin
      addend <= fmadAddIn;
      negLatch <= negate;
    end
  end

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      fmadDone <= 1'b0;
    end else begin
      fmadDone <= mulDone;
    end
  end

  // single add stage after the product settles
  always_ff @(posedge clock) begin
    if (mulDone) begin
      fmadOut <= negLatch ? (addend - product) : (addend + product);
    end
  end

endmodule : fmad

`default_nettype wire

/* verilog/newtonRaphsonReciprocal.sv */
// reciprocal of a normalized mantissa by table guess and Newton-Raphson refinement
`timescale 1ns/1ps
`default_nettype none

module nrrFSM (
  input  logic clock,
  input  logic reset,
  input  logic start,
  input  logic fmadDone,
  input  logic mulDone,
  input  logic itersDone,
  output logic fmadStart,
  output logic mulStart,
  output logic compEn,
  output logic nrrDone
);

  typedef enum logic [2:0] {
    NR_WAIT,
    NR_FMAD_KICK,
    NR_FMAD_WAIT,
    NR_MUL_KICK,
    NR_MUL_WAIT,
    NR_DONE
  } nrrState_t;

  nrrState_t currState;
  nrrState_t nextState;

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      currState <= NR_WAIT;
    end else begin
      currState <= nextState;
    end
  end

  always_comb begin
    nextState = currState;
    fmadStart = 1'b0;
    mulStart = 1'b0;
    compEn = 1'b0;
    nrrDone = 1'b0;
    unique case (currState)
      NR_WAIT: begin
        if (start) begin
          nextState = NR_FMAD_KICK;
        end
      end
      NR_FMAD_KICK: begin
        fmadStart = 1'b1;
        nextState = NR_FMAD_WAIT;
      end
      NR_FMAD_WAIT: begin
        if (fmadDone) begin
          nextState = NR_MUL_KICK;
        end
      end
      NR_MUL_KICK: begin
        mulStart = 1'b1;
        nextState = NR_MUL_WAIT;
      end
      NR_MUL_WAIT: begin
        // refined value is written back on the same edge
        if (mulDone) begin
          compEn = 1'b1;
          nextState = itersDone ? NR_DONE : NR_FMAD_KICK;
        end
      end
      NR_DONE: begin
        nrrDone = 1'b1;
        nextState = NR_WAIT;
      end
    endcase
  end

endmodule : nrrFSM

module newtonRaphsonReciprocal
  import nrDivPkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  logic              start,
  input  logic [WORD_W-1:0] nrrIn,
  output logic [WORD_W-1:0] nrrOut,
  output logic              nrrDone
);

  logic [ITER_W-1:0] iterCount;
  logic [PROD_W-1:0] errTerm;
  logic [PROD_W-1:0] refined;
  logic [WORD_W-1:0] scaledErr;
  logic              fmadStart;
  logic              fmadDone;
  logic              mulStart;
  logic              mulDone;
  logic              compEn;
  logic              itersDone;

  assign itersDone = (iterCount == ITER_W'(NR_ITERS - 1));
  // e >> FRAC_W back to word scale
  assign scaledErr = errTerm[FRAC_W +: WORD_W];

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      iterCount <= '0;
    end else if (start) begin
      iterCount <= '0;
    end else if (compEn) begin
      iterCount <= iterCount + 1'b1;
    end
  end

  // guess picked by the two fraction bits below the leading one
  always_ff @(posedge clock) begin
    if (start) begin
      nrrOut <= GUESS_LUT[nrrIn[FRAC_W-1 -: 2]];
    end else if (compEn) begin
      nrrOut <= refined[FRAC_W +: WORD_W];
    end
  end

  // e = 2 - d*x
  fmad errFmad (
    .clock,
    .reset,
    .start     (fmadStart),
    .fmadMulIn1(nrrIn),
    .fmadMulIn2(nrrOut),
    .fmadAddIn (TWO_PROD),
    .negate    (1'b1),
    .fmadOut   (errTerm),
    .fmadDone
  );

  radix16Mult refineMult (
    .clock,
    .reset,
    .start (mulStart),
    .mulIn1(nrrOut),
    .mulIn2(scaledErr),
    .mulOut(refined),
    .done  (mulDone)
  );

  nrrFSM fsm (
    .clock,
    .reset,
    .start,
    .fmadDone,
    .mulDone,
    .itersDone,
    .fmadStart,
    .mulStart,
    .compEn,
    .nrrDone
  );

  // error term has to fit the word slice fed to the refine multiply
  assert property (@(posedge clock) disable iff (reset)
                   fmadDone |-> (errTerm[PROD_W-1:FRAC_W+WORD_W] == '0))
    else $error("error term overflowed the slice used for refinement");

endmodule : newtonRaphsonReciprocal

`default_nettype wire

/* verilog/nrDivPkg.sv */
// widths, iteration constants, guess table and payload structs shared by the divider RTL
`default_nettype none

package nrDivPkg;

  localparam int DATA_W = 8;
  localparam int FRAC_W = 12;
  localparam int WORD_W = FRAC_W + 2;
  localparam int PROD_W = 2 * WORD_W;
  localparam int SHIFT_W = $clog2(DATA_W);
  localparam int NR_ITERS = 4;
  localparam int MULT_STEPS = (WORD_W + 3) / 4;
  localparam int ITER_W = $clog2(NR_ITERS);
  localparam int STEP_W = $clog2(MULT_STEPS);

  // 2.0 with 2*FRAC_W fraction bits, the addend of the error term
  localparam logic [PROD_W-1:0] TWO_PROD = PROD_W'(2) << (2 * FRAC_W);

  // 1/m at the midpoints 1.125, 1.375, 1.625, 1.875, truncated
  localparam logic [WORD_W-1:0] GUESS_LUT [4] = '{
    WORD_W'(3640),
    WORD_W'(2978),
    WORD_W'(2520),
    WORD_W'(2184)
  };

  typedef struct packed {
    logic [DATA_W-1:0] dividend;
    logic [DATA_W-1:0] divisor;
  } divReq_t;

  typedef struct packed {
    logic [DATA_W-1:0] quotient;
    logic              divByZero;
  } divResp_t;

  // mant holds the divisor scaled into [1, 2)
  typedef struct packed {
    logic [WORD_W-1:0]  mant;
    logic [SHIFT_W-1:0] shift;
    logic               isZero;
  } normDivisor_t;

endpackage : nrDivPkg

`default_nettype wire

/* verilog/nrDivider.sv */
// top of the unsigned Newton-Raphson divider with start/busy/done handshake
`timescale 1ns/1ps
`default_nettype none

module nrDivider
  import nrDivPkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     start,
  input  divReq_t  req,
  output divResp_t resp,
  output logic     busy,
  output logic     done
);

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RECIP,
    DIV_MULT,
    DIV_FINISH
  } divState_t;

  divState_t         state;
  divReq_t           reqReg;
  normDivisor_t      norm;
  logic              launch;
  logic              accept;
  logic              zeroSkip;
  logic              quotReady;
  logic              recipStart;
  logic              recipDone;
  logic [WORD_W-1:0] recip;
  logic              quotStart;
  logic              quotDone;
  logic [PROD_W-1:0] quotProd;
  logic [DATA_W-1:0] quotient;

  assign busy = (state != DIV_IDLE);
  assign accept = start && !busy;
  assign zeroSkip = (state == DIV_RECIP) && launch && norm.isZero;
  assign recipStart = (state == DIV_RECIP) && launch && !norm.isZero;
  assign quotStart = (state == DIV_MULT) && launch;
  assign quotReady = (state == DIV_MULT) && quotDone;
  // drop the fraction bits and undo the normalization
  assign quotient = DATA_W'(quotProd >> (FRAC_W + norm.shift));

  divNormalize normalizer (
    .divisor(reqReg.divisor),
    .norm
  );

  newtonRaphsonReciprocal reciprocal (
    .clock,
    .reset,
    .start  (recipStart),
    .nrrIn  (norm.mant),
    .nrrOut (recip),
    .nrrDone(recipDone)
  );

  radix16Mult quotMult (
    .clock,
    .reset,
    .start (quotStart),
    .mulIn1(WORD_W'(reqReg.dividend)),
    .mulIn2(recip),
    .mulOut(quotProd),
    .done  (quotDone)
  );

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      state <= DIV_IDLE;
      launch <= 1'b0;
      done <= 1'b0;
    end else begin
      launch <= 1'b0;
      done <= 1'b0;
      unique case (state)
        DIV_IDLE: begin
          if (accept) begin
            state <= DIV_RECIP;
            launch <= 1'b1;
          end
        end
        DIV_RECIP: begin
          if (zeroSkip) begin
            state <= DIV_FINISH;
            done <= 1'b1;
          end else if (recipDone) begin
            state <= DIV_MULT;
            launch <= 1'b1;
          end
        end
        DIV_MULT: begin
          if (quotDone) begin
            state <= DIV_FINISH;
            done <= 1'b1;
          end
        end
        DIV_FINISH: begin
          state <= DIV_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      reqReg <= req;
    end
    if (zeroSkip) begin
      resp <= '{quotient: {DATA_W{1'b1}}, divByZero: 1'b1};
    end else if (quotReady) begin
      resp <= '{quotient: quotient, divByZero: 1'b0};
    end
  end

  // request offered mid-division is dropped
  assert property (@(posedge clock) disable iff (reset) start |-> !busy)
    else $warning("start ignored while a division is running");

  // reciprocal unit only reports back while its result is awaited
  assert property (@(posedge clock) disable iff (reset) recipDone |-> (state == DIV_RECIP))
    else $error("reciprocal finished outside the reciprocal phase");

endmodule : nrDivider

`default_nettype wire

/* verilog/radix16Mult.sv */
// sequential unsigned multiplier, one radix-16 digit of the second operand per cycle
`timescale 1ns/1ps
`default_nettype none

module radix16Mult
  import nrDivPkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  logic              start,
  input  logic [WORD_W-1:0] mulIn1,
  input  logic [WORD_W-1:0] mulIn2,
  output logic [PROD_W-1:0] mulOut,
  output logic              done
);

  logic              running;
  logic [STEP_W-1:0] step;
  logic [PROD_W-1:0] mcand;
  logic [WORD_W-1:0] mplier;
  logic [PROD_W-1:0] partial;

  // shifted multiplicand times the current low digit
  assign partial = mcand * PROD_W'(mplier[3:0]);

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      running <= 1'b0;
      step <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        running <= 1'b1;
        step <= '0;
      end else if (running) begin
        step <= step + 1'b1;
        // last digit retires here, done shows next cycle
        if (step == STEP_W'(MULT_STEPS - 1)) begin
          running <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      mcand <= PROD_W'(mulIn1);
      mplier <= mulIn2;
      mulOut <= '0;
    end else if (running) begin
      mulOut <= mulOut + partial;
      mcand <= mcand << 4;
      mplier <= mplier >> 4;
    end
  end

  // callers wait for done before the next operand pair
  assert property (@(posedge clock) disable iff (reset) start |-> !running)
    else $error("radix16Mult started while a product was in progress");

endmodule : radix16Mult

`default_nettype wire
